// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/exu_adder.sv ====
// adder and subtractor with equality, less-than and greater-or-equal flags
`timescale 1ns/1ps

module exu_adder
(
   input  logic [exu_pkg::xlen-1:0] a,
   input  logic [exu_pkg::xlen-1:0] b,
   input  logic                     sub,
   input  logic                     unsign,
   output exu_pkg::alu_flags_t      flags
);

   import exu_pkg::*;

   logic [xlen-1:0] bm;
   logic [xlen-1:0] sum;
   logic            cout;
   logic            ov;
   logic            neg;
   logic            lt;

   // subtract as a plus inverted b plus one
   assign bm = sub ? ~b : b;

   assign {cout, sum} = {1'b0, a} + {1'b0, bm} + {{xlen{1'b0}}, sub};

   assign neg = sum[xlen-1];

   // signed overflow when the carry into the sign bit differs from the carry out
   assign ov = a[xlen-1] ^ bm[xlen-1] ^ sum[xlen-1] ^ cout;

   // a missing carry out of a - b means a < b unsigned
   assign lt = unsign ? ~cout : (neg ^ ov);

   assign flags = '{
      sum: sum,
      eq:  (a == b),
      lt:  lt,
      ge:  ~lt
   };

endmodule

// ==== hw/exu_alu_ctl.sv ====
// operation decode, logic and single-bit results, result select and the output register
`timescale 1ns/1ps

module exu_alu_ctl
(
   input  logic                        clk,
   input  logic                        arst_n,

   input  logic                        in_valid,
   output logic                        in_ready,
   input  exu_pkg::alu_req_t           req,

   output logic                        adder_sub_o,
   output logic                        adder_unsign_o,
   output logic [exu_pkg::shamt_w-1:0] shamt_o,
   output logic                        shift_sll_o,
   output logic                        shift_sra_o,
   output logic                        cnt_trailing_o,
   output logic                        cnt_zeros_o,

   input  exu_pkg::alu_flags_t         flags,
   input  logic [exu_pkg::xlen-1:0]    sout,
   input  logic [exu_pkg::cnt_w-1:0]   count,
   input  logic                        br_flush,
   input  logic [exu_pkg::pc_w-1:0]    br_path,

   output logic                        out_valid,
   input  logic                        out_ready,
   output exu_pkg::alu_rsp_t           rsp
);

   import exu_pkg::*;

   alu_op_e         op;
   logic            sel_sum;
   logic            sel_slt;
   logic            sel_shift;
   logic            sel_count;
   logic            sel_jump;
   logic            is_min;
   logic            is_minmax;
   logic            is_cond;
   logic            minmax_sel_a;
   logic [xlen-1:0] lout;
   logic [xlen-1:0] minmax_res;
   logic [xlen-1:0] sb_1hot;
   logic [xlen-1:0] sb_res;
   logic [xlen-1:0] link;
   logic [xlen-1:0] result;
   logic            load;

   assign op = req.op;

   assign sel_sum   = (op == op_add) | (op == op_sub);
   assign sel_slt   = (op == op_slt) | (op == op_sltu);
   assign sel_shift = (op == op_sll) | (op == op_srl) | (op == op_sra);
   assign sel_count = (op == op_clz) | (op == op_ctz) | (op == op_cpop);
   assign sel_jump  = (op == op_jal) | (op == op_jalr);
   assign is_min    = (op == op_min) | (op == op_minu);
   assign is_minmax = is_min | (op == op_max) | (op == op_maxu);
   assign is_cond   = (op == op_beq) | (op == op_bne) | (op == op_blt) |
                      (op == op_bge) | (op == op_bltu) | (op == op_bgeu);

   // every compare runs through a - b, jumps need a plain a + b
   assign adder_sub_o    = (op == op_sub) | sel_slt | is_minmax | is_cond;
   assign adder_unsign_o = (op == op_sltu) | (op == op_minu) | (op == op_maxu) |
                           (op == op_bltu) | (op == op_bgeu);

   // bext shifts right by the bit index and keeps bit 0
   assign shamt_o        = req.b[shamt_w-1:0];
   assign shift_sll_o    = (op == op_sll);
   assign shift_sra_o    = (op == op_sra);
   assign cnt_trailing_o = (op == op_ctz);
   assign cnt_zeros_o    = (op == op_clz) | (op == op_ctz);

   assign lout = ({xlen{op == op_and}} & (req.a & req.b)) |
                 ({xlen{op == op_or }} & (req.a | req.b)) |
                 ({xlen{op == op_xor}} & (req.a ^ req.b));

   // min keeps a when a < b, max keeps a when a >= b
   assign minmax_sel_a = flags.ge ^ is_min;
   assign minmax_res   = ({xlen{is_minmax &  minmax_sel_a}} & req.a) |
                         ({xlen{is_minmax & ~minmax_sel_a}} & req.b);

   assign sb_1hot = xlen'(1) << req.b[shamt_w-1:0];
   assign sb_res  = ({xlen{op == op_bset}} & (req.a |  sb_1hot)) |
                    ({xlen{op == op_bclr}} & (req.a & ~sb_1hot)) |
                    ({xlen{op == op_binv}} & (req.a ^  sb_1hot));

   assign link = req.pc + xlen'(inst_len);

   // at most one term is nonzero, branches leave all of them at zero
   assign result = ({xlen{sel_sum}}          & flags.sum) |
                   lout                                   |
                   ({xlen{sel_slt}}          & xlen'(flags.lt)) |
                   ({xlen{sel_shift}}        & sout) |
                   ({xlen{op == op_bext}}    & xlen'(sout[0])) |
                   ({xlen{sel_count}}        & xlen'(count)) |
                   minmax_res                             |
                   sb_res                                 |
                   ({xlen{sel_jump}}         & link);

   // a full stage still accepts when its output drains on the same edge
   assign in_ready = ~out_valid | out_ready;
   assign load     = in_valid & in_ready;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else if (in_ready)
         out_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (load)
         rsp <= '{result: result, flush: br_flush, flush_path: br_path};
   end

endmodule

// ==== hw/exu_alu_top.sv ====
// execute stage top level with the control block and the datapath units
`timescale 1ns/1ps

module exu_alu_top
(
   input  logic                clk,
   input  logic                arst_n,

   input  logic                in_valid,
   output logic                in_ready,
   input  exu_pkg::alu_req_t   req,

   output logic                out_valid,
   input  logic                out_ready,
   output exu_pkg::alu_rsp_t   rsp
);

   import exu_pkg::*;

   logic               adder_sub;
   logic               adder_unsign;
   logic [shamt_w-1:0] shamt;
   logic               shift_sll;
   logic               shift_sra;
   logic               cnt_trailing;
   logic               cnt_zeros;
   alu_flags_t         flags;
   logic [xlen-1:0]    sout;
   logic [cnt_w-1:0]   count;
   logic               br_flush;
   logic [pc_w-1:0]    br_path;

   exu_alu_ctl u_ctl
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .req            (req),
      .adder_sub_o    (adder_sub),
      .adder_unsign_o (adder_unsign),
      .shamt_o        (shamt),
      .shift_sll_o    (shift_sll),
      .shift_sra_o    (shift_sra),
      .cnt_trailing_o (cnt_trailing),
      .cnt_zeros_o    (cnt_zeros),
      .flags          (flags),
      .sout           (sout),
      .count          (count),
      .br_flush       (br_flush),
      .br_path        (br_path),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .rsp            (rsp)
   );

   exu_adder u_adder
   (
      .a      (req.a),
      .b      (req.b),
      .sub    (adder_sub),
      .unsign (adder_unsign),
      .flags  (flags)
   );

   exu_shifter u_shifter
   (
      .a     (req.a),
      .shamt (shamt),
      .sll   (shift_sll),
      .sra   (shift_sra),
      .sout  (sout)
   );

   exu_bitcount u_bitcount
   (
      .a           (req.a),
      .trailing    (cnt_trailing),
      .count_zeros (cnt_zeros),
      .count       (count)
   );

   // the taken bit is only needed inside the branch unit for now
   exu_branch u_branch
   (
      .req        (req),
      .flags      (flags),
      .taken      (),
      .flush      (br_flush),
      .flush_path (br_path)
   );

endmodule

// ==== hw/exu_bitcount.sv ====
// leading and trailing zero count and population count
`timescale 1ns/1ps

module exu_bitcount
(
   input  logic [exu_pkg::xlen-1:0]  a,
   input  logic                      trailing,
   input  logic                      count_zeros,
   output logic [exu_pkg::cnt_w-1:0] count
);

   import exu_pkg::*;

   logic [xlen-1:0]  a_rev;
   logic [xlen-1:0]  lzd_in;
   logic [cnt_w-1:0] lz_cnt;
   logic [cnt_w-1:0] pop_cnt;

   // trailing zeros of a are the leading zeros of a reversed
   assign a_rev  = {<<{a}};
   assign lzd_in = trailing ? a_rev : a;

   // highest set bit wins, an all-zero word gives xlen
   always_comb
   begin
      lz_cnt = cnt_w'(xlen);
      for (int i = 0; i < xlen; i++)
      begin
         if (lzd_in[i])
            lz_cnt = cnt_w'(xlen - 1 - i);
      end
   end

   always_comb
   begin
      pop_cnt = '0;
      for (int i = 0; i < xlen; i++)
      begin
         pop_cnt = pop_cnt + cnt_w'(a[i]);
      end
   end

   assign count = count_zeros ? lz_cnt : pop_cnt;

endmodule

// ==== hw/exu_branch.sv ====
// branch condition, misprediction flush and flush target for branches and jumps
`timescale 1ns/1ps

module exu_branch
(
   input  exu_pkg::alu_req_t       req,
   input  exu_pkg::alu_flags_t     flags,
   output logic                    taken,
   output logic                    flush,
   output logic [exu_pkg::pc_w-1:0] flush_path
);

   import exu_pkg::*;

   logic            is_beq;
   logic            is_bne;
   logic            is_blt;
   logic            is_bge;
   logic            is_cond;
   logic            is_jump;
   logic            cond_true;
   logic [pc_w-1:0] target;
   logic [pc_w-1:0] seq_pc;

   assign is_beq  = (req.op == op_beq);
   assign is_bne  = (req.op == op_bne);
   // the adder already picks signed or unsigned for lt and ge
   assign is_blt  = (req.op == op_blt) | (req.op == op_bltu);
   assign is_bge  = (req.op == op_bge) | (req.op == op_bgeu);
   assign is_cond = is_beq | is_bne | is_blt | is_bge;
   assign is_jump = (req.op == op_jal) | (req.op == op_jalr);

   assign cond_true = (is_beq &  flags.eq) |
                      (is_bne & ~flags.eq) |
                      (is_blt &  flags.lt) |
                      (is_bge &  flags.ge);

   assign taken = cond_true | is_jump;

   // separate target adder, the main adder is busy with the compare
   assign target = req.pc + {{(pc_w-brimm_w){req.brimm[brimm_w-1]}}, req.brimm};
   assign seq_pc = req.pc + pc_w'(inst_len);

   // jumps always redirect fetch, branches only on a wrong guess
   assign flush = (is_cond & (taken ^ req.predict_t)) | is_jump;

   always_comb
   begin
      flush_path = '0;
      if (is_jump)
         flush_path = {flags.sum[pc_w-1:1], 1'b0};
      else if (is_cond)
         flush_path = taken ? target : seq_pc;
   end

endmodule

// ==== hw/exu_pkg.sv ====
// widths, operation encoding and the request, flag and response packets of the execute stage
package exu_pkg;

   // datapath widths
   localparam int xlen     = 32;
   localparam int shamt_w  = 5;
   localparam int cnt_w    = 6;
   localparam int pc_w     = 32;
   localparam int brimm_w  = 13;

   // link increment, only 32-bit instructions are issued here
   localparam int inst_len = 4;

   // operations handled by the stage, op_nop produces a zero result
   typedef enum logic [5:0]
   {
      op_nop  = 6'd0,
      // base alu
      op_add  = 6'd1,
      op_sub  = 6'd2,
      op_and  = 6'd3,
      op_or   = 6'd4,
      op_xor  = 6'd5,
      op_slt  = 6'd6,
      op_sltu = 6'd7,
      op_sll  = 6'd8,
      op_srl  = 6'd9,
      op_sra  = 6'd10,
      // zbb subset
      op_clz  = 6'd16,
      op_ctz  = 6'd17,
      op_cpop = 6'd18,
      op_min  = 6'd19,
      op_max  = 6'd20,
      op_minu = 6'd21,
      op_maxu = 6'd22,
      // zbs
      op_bset = 6'd24,
      op_bclr = 6'd25,
      op_binv = 6'd26,
      op_bext = 6'd27,
      // branches and jumps
      op_beq  = 6'd32,
      op_bne  = 6'd33,
      op_blt  = 6'd34,
      op_bge  = 6'd35,
      op_bltu = 6'd36,
      op_bgeu = 6'd37,
      op_jal  = 6'd40,
      op_jalr = 6'd41
   } alu_op_e;

   // one operation as issued by decode
   typedef struct packed
   {
      alu_op_e              op;
      logic [xlen-1:0]      a;
      logic [xlen-1:0]      b;
      logic [pc_w-1:0]      pc;
      // signed byte offset of a conditional branch
      logic [brimm_w-1:0]   brimm;
      logic                 predict_t;
   } alu_req_t;

   // adder sum and compare flags
   typedef struct packed
   {
      logic [xlen-1:0]      sum;
      logic                 eq;
      logic                 lt;
      logic                 ge;
   } alu_flags_t;

   // registered result of the stage
   typedef struct packed
   {
      logic [xlen-1:0]      result;
      logic                 flush;
      logic [pc_w-1:0]      flush_path;
   } alu_rsp_t;

endpackage

// ==== hw/exu_shifter.sv ====
// logical and arithmetic shifter on a double-width word, also feeding bit extract
`timescale 1ns/1ps

module exu_shifter
(
   input  logic [exu_pkg::xlen-1:0]    a,
   input  logic [exu_pkg::shamt_w-1:0] shamt,
   input  logic                        sll,
   input  logic                        sra,
   output logic [exu_pkg::xlen-1:0]    sout
);

   import exu_pkg::*;

   logic [shamt_w-1:0] amount;
   logic [2*xlen-2:0]  extend;
   logic [xlen-1:0]    shifted;
   logic [xlen-1:0]    mask;

   // a left shift by n is a right shift by 32 - n of the extended word
   assign amount = sll ? (~shamt + shamt_w'(1)) : shamt;

   assign extend[xlen-1:0] = a;

   // upper half holds sign fill for sra, a copy of a for sll, zero for srl
   assign extend[2*xlen-2:xlen] = ({(xlen-1){sra & a[xlen-1]}}) |
                                  ({(xlen-1){sll}} & a[xlen-2:0]);

   assign shifted = xlen'(extend >> amount);

   // clear the low bits that wrapped in from the copy on a left shift
   assign mask = {xlen{1'b1}} << (sll ? shamt : shamt_w'(0));

   assign sout = shifted & mask;

endmodule

// ==== sources.f ====
hw/exu_pkg.sv
hw/exu_adder.sv
hw/exu_shifter.sv
hw/exu_bitcount.sv
hw/exu_branch.sv
hw/exu_alu_ctl.sv
hw/exu_alu_top.sv
tb/exu_clkgen.sv
tb/exu_alu_assert.sv
tb/exu_tb.sv

// ==== tb/exu_alu_assert.sv ====
// handshake assertions for the execute stage top level, with their bind
`timescale 1ns/1ps

module exu_alu_assert
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              in_ready,
   input  logic              out_valid,
   input  logic              out_ready,
   input  exu_pkg::alu_rsp_t rsp
);

   // the stage comes out of reset empty and ready
   a_reset_state: assert property (@(posedge clk) !arst_n |=> (!out_valid && in_ready))
      else $error("out_valid or in_ready wrong after reset");

   // a stalled response must not move
   a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(rsp)))
      else $error("response changed while stalled");

   a_ready_rule: assert property (@(posedge clk) disable iff (!arst_n)
      in_ready == (!out_valid || out_ready))
      else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind exu_alu_top exu_alu_assert assert0
(
   .clk       (clk),
   .arst_n    (arst_n),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .rsp       (rsp)
);

// ==== tb/exu_clkgen.sv ====
// clock and reset generator for the execute stage testbench
`timescale 1ns/1ps

module exu_clkgen
(
   output logic clk,
   output logic arst_n
);

   localparam int half_period  = 4;
   localparam int reset_cycles = 3;

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // release a little after the edge so no flop sees it change at the edge
   initial
   begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule

// ==== tb/exu_tb.sv ====
// directed tests, reference model, response checker and watchdog for the execute stage
`timescale 1ns/1ps

module exu_tb;

   import exu_pkg::*;

   localparam int n_rand    = 8;
   localparam int n_bp_slow = 40;
   localparam int n_bp_fast = 16;
   localparam int n_bp      = n_bp_slow + n_bp_fast;
   localparam int total_ops = 7 * 9 + 7 * n_rand + 3 * 32 * 2 + 3 * 38 + 4 * 8 + 4 * 16 +
                              6 * 3 * 2 + 2 * 4 + n_bp;

   logic       clk;
   logic       arst_n;
   logic       in_valid;
   logic       in_ready;
   logic       out_valid;
   logic       out_ready;
   alu_req_t   req;
   alu_rsp_t   rsp;

   alu_rsp_t   exp_q[$];
   string      test_name;
   int         n_errors = 0;
   int         n_checks = 0;
   int         cycle = 0;
   int         rsp_at[n_bp];

   alu_op_e base_ops[7]   = '{op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu};
   alu_op_e mixed_ops[12] = '{op_add, op_sub, op_xor, op_sll, op_sra, op_clz, op_cpop,
                              op_maxu, op_bset, op_bext, op_bltu, op_jalr};
   logic [31:0] corner[3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};

   exu_clkgen clkgen0 (.clk(clk), .arst_n(arst_n));

   exu_alu_top dut0
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .req       (req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .rsp       (rsp)
   );

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] got);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("[ERROR] %s: expected %h, got %h", what, exp, got);
      end
   endtask

   // expected response of one request
   function automatic alu_rsp_t predict_rsp(input alu_req_t r);
      alu_rsp_t    e;
      logic [31:0] a;
      logic [31:0] b;
      int          sh;
      int          n;
      bit          taken;
      bit          is_br;
      e     = '0;
      a     = r.a;
      b     = r.b;
      sh    = int'(b[4:0]);
      n     = 0;
      taken = 0;
      is_br = r.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
      case (r.op)
         op_add:  e.result = a + b;
         op_sub:  e.result = a - b;
         op_and:  e.result = a & b;
         op_or:   e.result = a | b;
         op_xor:  e.result = a ^ b;
         op_slt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         op_sltu: e.result = (a < b) ? 32'd1 : 32'd0;
         op_sll:  e.result = a << sh;
         op_srl:  e.result = a >> sh;
         op_sra:  e.result = $signed(a) >>> sh;
         op_clz:
         begin
            while (n < 32 && !a[31 - n])
               n++;
            e.result = 32'(n);
         end
         op_ctz:
         begin
            while (n < 32 && !a[n])
               n++;
            e.result = 32'(n);
         end
         op_cpop: e.result = 32'($countones(a));
         op_min:  e.result = ($signed(a) < $signed(b)) ? a : b;
         op_max:  e.result = ($signed(a) > $signed(b)) ? a : b;
         op_minu: e.result = (a < b) ? a : b;
         op_maxu: e.result = (a > b) ? a : b;
         op_bset: e.result = a | (32'd1 << sh);
         op_bclr: e.result = a & ~(32'd1 << sh);
         op_binv: e.result = a ^ (32'd1 << sh);
         op_bext: e.result = 32'(a[sh]);
         op_beq:  taken = (a == b);
         op_bne:  taken = (a != b);
         op_blt:  taken = ($signed(a) < $signed(b));
         op_bge:  taken = ($signed(a) >= $signed(b));
         op_bltu: taken = (a < b);
         op_bgeu: taken = (a >= b);
         op_jal, op_jalr:
         begin
            e.result     = r.pc + 32'(inst_len);
            e.flush      = 1'b1;
            e.flush_path = (a + b) & ~32'd1;
         end
         default: ;
      endcase
      if (is_br)
      begin
         e.flush      = (taken != r.predict_t);
         e.flush_path = taken ? r.pc + 32'($signed(r.brimm)) : r.pc + 32'(inst_len);
      end
      return e;
   endfunction

   function automatic alu_req_t make_req(input alu_op_e op, input logic [31:0] a,
                                         input logic [31:0] b);
      alu_req_t r;
      r           = '0;
      r.op        = op;
      r.a         = a;
      r.b         = b;
      r.pc        = $urandom();
      r.brimm     = 13'($urandom());
      r.predict_t = 1'($urandom());
      return r;
   endfunction

   // returns 1 ns after the accepting edge with in_valid still high
   task automatic send_req(input alu_req_t r);
      bit rdy;
      in_valid = 1'b1;
      req      = r;
      do
      begin
         @(negedge clk);
         rdy = in_ready;
         @(posedge clk);
         #1;
      end
      while (!rdy);
      exp_q.push_back(predict_rsp(r));
   endtask

   // stall makes out_ready low on about two cycles of three
   task automatic recv_rsp(input bit stall, output int at);
      bit       fired;
      alu_rsp_t got;
      alu_rsp_t exp;
      fired = 0;
      while (!fired)
      begin
         out_ready = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
         @(negedge clk);
         if (out_valid && out_ready)
         begin
            fired = 1;
            got   = rsp;
            at    = cycle;
         end
         @(posedge clk);
         #1;
      end
      if (exp_q.size() == 0)
      begin
         n_errors++;
         $display("%s: the DUT returned a response that no request asked for", test_name);
      end
      else
      begin
         exp = exp_q.pop_front();
         check({test_name, " result"}, exp.result, got.result);
         check({test_name, " flush"}, 32'(exp.flush), 32'(got.flush));
         check({test_name, " flush_path"}, exp.flush_path, got.flush_path);
      end
   endtask

   // one cycle of latency puts the response before the edge after the accepting one
   task automatic run_op(input alu_req_t r);
      int sent;
      int at;
      send_req(r);
      sent     = cycle;
      in_valid = 1'b0;
      recv_rsp(1'b0, at);
      check({test_name, " latency"}, 32'(sent), 32'(at));
   endtask

   task automatic alu_basics();
      test_name = "base_alu";
      foreach (base_ops[k])
      begin
         foreach (corner[i])
            foreach (corner[j])
               run_op(make_req(base_ops[k], corner[i], corner[j]));
         for (int i = 0; i < n_rand; i++)
            run_op(make_req(base_ops[k], $urandom(), $urandom()));
      end
   endtask

   // upper bits of b are random so only b[4:0] may matter
   task automatic shift_sweep();
      alu_op_e ops[3] = '{op_sll, op_srl, op_sra};
      test_name = "shifts";
      foreach (ops[k])
         for (int amt = 0; amt < 32; amt++)
         begin
            run_op(make_req(ops[k], $urandom(), ($urandom() & ~32'h1f) | 32'(amt)));
            run_op(make_req(ops[k], $urandom() | 32'h8000_0000,
                            ($urandom() & ~32'h1f) | 32'(amt)));
         end
   endtask

   task automatic count_and_minmax();
      alu_op_e     cnt_ops[3] = '{op_clz, op_ctz, op_cpop};
      alu_op_e     mm_ops[4]  = '{op_min, op_max, op_minu, op_maxu};
      logic [31:0] words[$];
      logic [31:0] a;
      logic [31:0] b;
      test_name = "bitcount";
      words.push_back(32'h0);
      words.push_back(32'hffff_ffff);
      for (int i = 0; i < 32; i++)
         words.push_back(32'd1 << i);
      for (int i = 0; i < 4; i++)
         words.push_back($urandom());
      foreach (cnt_ops[k])
         foreach (words[i])
            run_op(make_req(cnt_ops[k], words[i], $urandom()));
      test_name = "minmax";
      foreach (mm_ops[k])
         for (int i = 0; i < 8; i++)
         begin
            a = (i % 2 == 0) ? ($urandom() | 32'h8000_0000) : ($urandom() & 32'h7fff_ffff);
            b = (i % 2 == 0) ? ($urandom() & 32'h7fff_ffff) : ($urandom() | 32'h8000_0000);
            run_op(make_req(mm_ops[k], a, b));
         end
   endtask

   task automatic single_bit_ops();
      alu_op_e ops[4] = '{op_bset, op_bclr, op_binv, op_bext};
      test_name = "single_bit";
      foreach (ops[k])
         for (int i = 0; i < 16; i++)
            run_op(make_req(ops[k], $urandom(), $urandom()));
   endtask

   // each operand pair makes some branch true and another false
   task automatic branch_and_jump();
      alu_op_e     ops[6] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
      logic [31:0] pa[3]  = '{32'hffff_ffff, 32'h1, 32'h5};
      logic [31:0] pb[3]  = '{32'h1, 32'hffff_ffff, 32'h5};
      alu_req_t    r;
      test_name = "branches";
      foreach (ops[k])
         foreach (pa[i])
            for (int p = 0; p < 2; p++)
            begin
               r           = make_req(ops[k], pa[i], pb[i]);
               r.predict_t = 1'(p);
               run_op(r);
            end
      test_name = "jumps";
      for (int i = 0; i < 4; i++)
      begin
         r   = make_req(op_jal, 32'h0, $urandom());
         r.a = r.pc;
         run_op(r);
         run_op(make_req(op_jalr, $urandom(), $urandom()));
      end
   endtask

   task automatic backpressure_stream();
      test_name = "backpressure";
      fork
         begin
            for (int i = 0; i < n_bp; i++)
               send_req(make_req(mixed_ops[$urandom_range(0, 11)], $urandom(), $urandom()));
            in_valid = 1'b0;
         end
         begin
            for (int i = 0; i < n_bp; i++)
               recv_rsp(i < n_bp_slow, rsp_at[i]);
         end
      join
      check("backpressure cycles", 32'(n_bp_fast - 1),
            32'(rsp_at[n_bp - 1] - rsp_at[n_bp_slow]));
   endtask

   initial
   begin
      repeat (total_ops * 20) @(posedge clk);
      $display("watchdog: the tests did not finish within %0d cycles", total_ops * 20);
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h42e3));
      in_valid  = 1'b0;
      out_ready = 1'b1;
      req       = '0;
      wait (arst_n);
      @(posedge clk);
      #1;
      alu_basics();
      shift_sweep();
      count_and_minmax();
      single_bit_ops();
      branch_and_jump();
      backpressure_stream();
      if (exp_q.size() != 0)
      begin
         n_errors++;
         $display("%0d accepted requests never produced a response", exp_q.size());
      end
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
